// File: hdl/bert_defines.svh
//------------------------------
// BERT TX size defines
// Lane count, generator count and seed width
//------------------------------

`ifndef BERT_DEFINES_SVH
`define BERT_DEFINES_SVH

// Even number of transmit lanes
`define BERT_LANES 8

// Number of pattern generators
`define BERT_GENS 4

// Seed and generator state width
`define BERT_SEED_W 32

`endif

// File: hdl/bert_pkg.sv
//------------------------------
// BERT TX shared types
// Pattern codes, config structs and lane vectors
//------------------------------

`include "bert_defines.svh"

`default_nettype none

package bert_pkg;

  // Pattern select codes with unlisted codes acting as PAT32
  typedef enum logic [2:0] {
    PAT32  = 3'd0,                       // 32-bit rotating pattern
    PRBS7  = 3'd1,                       // x^7 + x^6 + 1
    PRBS15 = 3'd2,                       // x^15 + x^14 + 1
    PRBS23 = 3'd3,                       // x^23 + x^18 + 1
    PRBS31 = 3'd4                        // x^31 + x^28 + 1
  } ptrn_sel_e;

  typedef enum logic [1:0] {
    FIFO_1X,                             // Full rate
    FIFO_2X,                             // Half rate
    FIFO_4X,                             // Quarter rate
    FIFO_REG                             // Register mode
  } fifo_mode_e;

  typedef struct packed {
    logic       gen2_mode;               // Gen2 bit layout
    logic       sdr_mode;                // Single data rate
    fifo_mode_e fifo_mode;               // TX FIFO ratio
  } bert_cfg_t;

  typedef struct packed {
    logic      start;                    // Start pulse
    logic      restart;                  // Stop and reload seed
    logic      seed_ld;                  // Seed load pulse
    ptrn_sel_e ptrn_sel;                 // Pattern choice
  } gen_ctrl_t;

  typedef gen_ctrl_t [`BERT_GENS-1:0]        gen_ctrl_arr_t;
  typedef logic [`BERT_GENS-1:0][7:0]        gen_bytes_t;
  typedef logic [`BERT_LANES-1:0][7:0]       lane_bytes_t;
  typedef logic [`BERT_LANES-1:0][1:0]       lane_sel_t;
  typedef logic [8*`BERT_LANES-1:0]          bert_word_t;

  // Shift exponent where bits per clock is 2**result
  function automatic logic [1:0] bert_shift_count(input bert_cfg_t cfg);
    logic [1:0] base;
    case (cfg.fifo_mode)
      FIFO_2X: base = 2'd1;
      FIFO_4X: base = 2'd2;
      default: base = 2'd0;              // 1X and register mode
    endcase
    return base + {1'b0, ~cfg.sdr_mode}; // DDR doubles the rate
  endfunction

endpackage

`default_nettype wire

// File: hdl/bert_gen.sv
//------------------------------
// BERT pattern generator
// PRBS or 32-bit rotate at 1 to 8 steps per clock
//------------------------------

`include "bert_defines.svh"

`default_nettype none

module bert_gen (
  input  wire                          clk,       // BERT clock
  input  wire                          rst_n,     // Async active-low reset
  input  wire bert_pkg::gen_ctrl_t     ctrl,      // Pulses and pattern select
  input  wire [`BERT_SEED_W-1:0]       seed_data, // Shared seed bus
  input  wire [1:0]                    shift_cnt, // Log2 of steps per clock
  output logic                         seed_good, // Stored seed nonzero
  output logic                         run,       // Generator running
  output logic [7:0]                   gen_byte   // Byte out
);

  localparam int W = `BERT_SEED_W;

  logic [W-1:0] seed_q;                  // Stored seed
  logic [W-1:0] state_q;                 // LFSR / rotate state
  logic [W-1:0] step_chain [0:8];        // Unrolled single steps
  logic [W-1:0] state_step;              // State after this clock's steps

  //------------------------------
  // Single step
  //------------------------------

  // One bit of LFSR feedback or one bit of rotation
  function automatic logic [W-1:0] step_one(
    input logic [W-1:0]        s,
    input bert_pkg::ptrn_sel_e sel
  );
    logic nb;
    case (sel)
      bert_pkg::PRBS7:  nb = s[6] ^ s[5];    // Taps 7,6
      bert_pkg::PRBS15: nb = s[14] ^ s[13];  // Taps 15,14
      bert_pkg::PRBS23: nb = s[22] ^ s[17];  // Taps 23,18
      bert_pkg::PRBS31: nb = s[30] ^ s[27];  // Taps 31,28
      default:          nb = s[W-1];         // PAT32 wraps MSB around
    endcase
    return {s[W-2:0], nb};                   // Shift left with new bit at LSB
  endfunction

  //------------------------------
  // Multi-step unroll
  //------------------------------

  always_comb
  begin
    step_chain[0] = state_q;
    for (int i = 1; i <= 8; i++)
    begin
      step_chain[i] = step_one(step_chain[i-1], ctrl.ptrn_sel);
    end
  end

  always_comb
  begin
    case (shift_cnt)
      2'd0:    state_step = step_chain[1];   // 1 bit per clock
      2'd1:    state_step = step_chain[2];   // 2 bits per clock
      2'd2:    state_step = step_chain[4];   // 4 bits per clock
      default: state_step = step_chain[8];   // 8 bits per clock
    endcase
  end

  //------------------------------
  // Seed and run control
  //------------------------------

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      seed_q    <= '0;
      seed_good <= 1'b0;
    end
    else if (ctrl.seed_ld)
    begin
      seed_q    <= seed_data;                // Capture shared bus
      seed_good <= |seed_data;               // All-zero seed locks LFSR
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      run <= 1'b0;
    else if (ctrl.restart)
      run <= 1'b0;                           // Restart wins over start
    else if (ctrl.start && seed_good)
      run <= 1'b1;                           // Only with a usable seed
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= '0;
    else if (ctrl.seed_ld)
      state_q <= seed_data;                  // New seed straight in
    else if (ctrl.restart)
      state_q <= seed_q;                     // Back to sequence start
    else if (run)
      state_q <= state_step;
  end

  assign gen_byte = state_q[7:0];            // Low byte with no extra delay

endmodule

`default_nettype wire

// File: hdl/bert_lane_sel.sv
//------------------------------
// BERT lane source select
// Registered generator pick per lane
//------------------------------

`include "bert_defines.svh"

`default_nettype none

module bert_lane_sel (
  input  wire                         clk,        // BERT clock
  input  wire                         rst_n,      // Async active-low reset
  input  wire bert_pkg::gen_bytes_t   gen_bytes,  // One byte per generator
  input  wire bert_pkg::lane_sel_t    lane_sel,   // Generator index per lane
  output bert_pkg::lane_bytes_t       lane_bytes  // Registered lane bytes
);

  bert_pkg::lane_bytes_t mux_out;                 // Unregistered lane bytes

  //------------------------------
  // Per-lane source mux
  //------------------------------

  always_comb
  begin
    for (int q = 0; q < `BERT_LANES; q++)
    begin
      case (lane_sel[q])
        2'd0:    mux_out[q] = gen_bytes[0];       // Generator 0
        2'd1:    mux_out[q] = gen_bytes[1];       // Generator 1
        2'd2:    mux_out[q] = gen_bytes[2];       // Generator 2
        default: mux_out[q] = gen_bytes[3];       // Generator 3
      endcase
    end
  end

  //------------------------------
  // Pipeline stage
  //------------------------------

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      lane_bytes <= '0;
    else
      lane_bytes <= mux_out;                      // One cycle of latency
  end

endmodule

`default_nettype wire

// File: hdl/bert_bit_map.sv
//------------------------------
// BERT output bit mapper
// Registered Gen1 SDR/DDR or Gen2 placement
//------------------------------

`include "bert_defines.svh"

`default_nettype none

module bert_bit_map (
  input  wire                         clk,        // BERT clock
  input  wire                         rst_n,      // Async active-low reset
  input  wire bert_pkg::bert_cfg_t    cfg,        // Gen and rate mode
  input  wire bert_pkg::lane_bytes_t  lane_bytes, // Selected lane bytes
  output bert_pkg::bert_word_t        bert_data   // Wide TX word
);

  localparam int L = `BERT_LANES;                 // Even lane count

  bert_pkg::bert_word_t word_g2;                  // Gen2 layout
  bert_pkg::bert_word_t word_g1_ddr;              // Gen1 double rate
  bert_pkg::bert_word_t word_g1_sdr;              // Gen1 single rate
  bert_pkg::bert_word_t word_nxt;                 // Selected layout

  //------------------------------
  // Gen2 layout
  //------------------------------

  // Four groups of 2L bits with one bit pair per lane
  always_comb
  begin
    word_g2 = '0;
    for (int g = 0; g < 4; g++)
    begin
      for (int q = 0; q < L; q++)
      begin
        word_g2[2*g*L+2*q]   = lane_bytes[q][7-2*g];  // Even slot
        word_g2[2*g*L+2*q+1] = lane_bytes[q][6-2*g];  // Odd slot
      end
    end
  end

  //------------------------------
  // Gen1 layouts
  //------------------------------

  // Lower 2L bits from the first L/2 lanes
  always_comb
  begin
    word_g1_ddr = word_g2;                        // Upper bits keep Gen2
    for (int g = 0; g < 2; g++)
    begin
      for (int q = 0; q < L/2; q++)
      begin
        word_g1_ddr[g*L+2*q]   = lane_bytes[q][7-2*g];
        word_g1_ddr[g*L+2*q+1] = lane_bytes[q][6-2*g];
      end
    end
  end

  // SDR replaces only the even positions
  always_comb
  begin
    word_g1_sdr = word_g1_ddr;
    for (int g = 0; g < 2; g++)
    begin
      for (int q = 0; q < L/2; q++)
      begin
        word_g1_sdr[g*L+2*q] = lane_bytes[q][7-g];  // One new bit per lane
      end
    end
  end

  //------------------------------
  // Output select and register
  //------------------------------

  always_comb
  begin
    if (cfg.gen2_mode)
      word_nxt = word_g2;
    else if (cfg.sdr_mode)
      word_nxt = word_g1_sdr;
    else
      word_nxt = word_g1_ddr;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      bert_data <= '0;
    else
      bert_data <= word_nxt;                      // Second pipeline stage
  end

endmodule

`default_nettype wire

// File: hdl/bert_tx.sv
//------------------------------
// BERT transmit top
// Generators, lane select and bit map in a chain
//------------------------------

`include "bert_defines.svh"

`default_nettype none

module bert_tx (
  input  wire                           clk,        // BERT clock
  input  wire                           rst_n,      // Async active-low reset
  input  wire bert_pkg::bert_cfg_t      cfg,        // Quasi-static mode
  input  wire bert_pkg::gen_ctrl_arr_t  gen_ctrl,   // Per-generator control
  input  wire [`BERT_SEED_W-1:0]        seed_data,  // Shared seed bus
  input  wire bert_pkg::lane_sel_t      lane_sel,   // Lane source select
  output logic [`BERT_GENS-1:0]         seed_good,  // Seed nonzero per gen
  output logic [`BERT_GENS-1:0]         gen_run,    // Running per gen
  output bert_pkg::bert_word_t          bert_data   // Wide TX word
);

  bert_pkg::gen_bytes_t  gen_bytes;                 // Generator outputs
  bert_pkg::lane_bytes_t lane_bytes;                // Registered lane bytes

  //------------------------------
  // Pattern generators
  //------------------------------

  for (genvar i = 0; i < `BERT_GENS; i++)
  begin : g_gen
    bert_gen u_bert_gen (
      .clk       (clk),
      .rst_n     (rst_n),
      .ctrl      (gen_ctrl[i]),
      .seed_data (seed_data),
      .shift_cnt (bert_pkg::bert_shift_count(cfg)), // Same rate for all
      .seed_good (seed_good[i]),
      .run       (gen_run[i]),
      .gen_byte  (gen_bytes[i])
    );
  end

  //------------------------------
  // Lane select and mapping
  //------------------------------

  bert_lane_sel u_bert_lane_sel (
    .clk        (clk),
    .rst_n      (rst_n),
    .gen_bytes  (gen_bytes),
    .lane_sel   (lane_sel),
    .lane_bytes (lane_bytes)
  );

  bert_bit_map u_bert_bit_map (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg        (cfg),
    .lane_bytes (lane_bytes),
    .bert_data  (bert_data)                         // Two stages after state
  );

endmodule

`default_nettype wire

// File: sim/bert_tx_checker.sv
//------------------------------
// BERT TX assertion checker
// Run control, restart and reset state rules
//------------------------------

`include "bert_defines.svh"

`default_nettype none

module bert_tx_checker (
  input wire                          clk,        // BERT clock
  input wire                          rst_n,      // Async active-low reset
  input wire bert_pkg::gen_ctrl_arr_t gen_ctrl,   // Per-generator control
  input wire [`BERT_GENS-1:0]         seed_good,  // Seed nonzero per gen
  input wire [`BERT_GENS-1:0]         gen_run,    // Running per gen
  input wire bert_pkg::bert_word_t    bert_data   // Wide TX word
);

  timeunit 1ns;
  timeprecision 1ps;

  for (genvar i = 0; i < `BERT_GENS; i++)
  begin : g_chk
    // Run only starts from a good seed
    a_run_needs_seed : assert property (@(posedge clk) disable iff (!rst_n)
      $rose(gen_run[i]) |-> $past(seed_good[i]))
      else $error("gen_run[%0d] rose without a good seed", i);

    // Restart stops the generator one edge later
    a_restart_stops : assert property (@(posedge clk) disable iff (!rst_n)
      gen_ctrl[i].restart |=> !gen_run[i])
      else $error("gen_run[%0d] still high after restart", i);
  end

  a_reset_word : assert property (@(posedge clk) !rst_n |-> bert_data == '0)
    else $error("bert_data not zero during reset");

endmodule

bind bert_tx bert_tx_checker u_bert_tx_checker (
  .clk       (clk),
  .rst_n     (rst_n),
  .gen_ctrl  (gen_ctrl),
  .seed_good (seed_good),
  .gen_run   (gen_run),
  .bert_data (bert_data)
);

`default_nettype wire

// File: sim/bert_tx_tb.sv
//------------------------------
// BERT TX directed testbench
// Reference model, compare tasks, watchdog
//------------------------------

`include "bert_defines.svh"

`default_nettype none

module bert_tx_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 40;
  localparam int L = `BERT_LANES;
  // Cycle budgets for reset, six tests and margin
  localparam int WATCH_CYCLES = 20 + 20 + 60 + 200 + 80 + 80 + 60 + 100;
  localparam int PULSE_START = 0;
  localparam int PULSE_RESTART = 1;

  logic clk;
  logic rst_n;
  bert_pkg::bert_cfg_t     cfg;
  bert_pkg::gen_ctrl_arr_t gen_ctrl;
  logic [`BERT_SEED_W-1:0] seed_data;
  bert_pkg::lane_sel_t     lane_sel;
  logic [`BERT_GENS-1:0]   seed_good;
  logic [`BERT_GENS-1:0]   gen_run;
  bert_pkg::bert_word_t    bert_data;

  // Reference model state
  logic [`BERT_GENS-1:0][`BERT_SEED_W-1:0] m_seed;
  logic [`BERT_GENS-1:0][`BERT_SEED_W-1:0] m_state;
  logic [`BERT_GENS-1:0] m_run;
  logic [`BERT_GENS-1:0] m_good;
  bert_pkg::lane_bytes_t m_lane_q;               // Model lane stage
  bert_pkg::bert_word_t  m_word;                 // Model output stage
  bert_pkg::bert_word_t  trace [0:31];           // Last words seen
  bert_pkg::bert_word_t  first_run [0:11];       // Words of first run

  int seed_var;
  int errors;
  int checks;
  int tests_run;
  int tests_failed;

  bert_tx u_bert_tx (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .gen_ctrl  (gen_ctrl),
    .seed_data (seed_data),
    .lane_sel  (lane_sel),
    .seed_good (seed_good),
    .gen_run   (gen_run),
    .bert_data (bert_data)
  );

  //------------------------------
  // Model rules
  //------------------------------

  function automatic int steps_per_clock(input bert_pkg::bert_cfg_t c);
    int n;
    case (c.fifo_mode)
      bert_pkg::FIFO_2X: n = 2;
      bert_pkg::FIFO_4X: n = 4;
      default:           n = 1;                  // 1X and REG
    endcase
    return c.sdr_mode ? n : 2 * n;               // DDR doubles
  endfunction

  function automatic logic [31:0] advance(input logic [31:0] s,
                                          input bert_pkg::ptrn_sel_e sel, input int n);
    int deg;
    int tap;
    logic fb;
    case (sel)
      bert_pkg::PRBS7:  {deg, tap} = {32'd7, 32'd6};
      bert_pkg::PRBS15: {deg, tap} = {32'd15, 32'd14};
      bert_pkg::PRBS23: {deg, tap} = {32'd23, 32'd18};
      bert_pkg::PRBS31: {deg, tap} = {32'd31, 32'd28};
      default:          {deg, tap} = {32'd0, 32'd0}; // Rotate
    endcase
    for (int k = 0; k < n; k++)
    begin
      fb = (deg == 0) ? s[31] : s[deg-1] ^ s[tap-1];
      s = {s[30:0], fb};
    end
    return s;
  endfunction

  // Source lane and bit for each output position
  function automatic bert_pkg::bert_word_t build_word(input bert_pkg::lane_bytes_t lanes,
                                                      input bert_pkg::bert_cfg_t c);
    bert_pkg::bert_word_t w;
    int g;
    int q;
    int b;
    for (int p = 0; p < 8*L; p++)
    begin
      g = p / (2*L);
      q = (p % (2*L)) / 2;
      b = (p % 2) ? 6 - 2*g : 7 - 2*g;
      if (!c.gen2_mode && p < 2*L)
      begin
        g = p / L;                               // Gen1 groups are L wide
        q = (p % L) / 2;
        b = (p % 2) ? 6 - 2*g : (c.sdr_mode ? 7 - g : 7 - 2*g);
      end
      w[p] = lanes[q][b];
    end
    return w;
  endfunction

  // Gen2 inverse from word back to lane bytes
  function automatic bert_pkg::lane_bytes_t recover_lanes(input bert_pkg::bert_word_t w);
    bert_pkg::lane_bytes_t r;
    for (int q = 0; q < L; q++)
      for (int g = 0; g < 4; g++)
        {r[q][7-2*g], r[q][6-2*g]} = {w[2*g*L+2*q], w[2*g*L+2*q+1]};
    return r;
  endfunction

  function automatic logic [31:0] random_seed();
    logic [31:0] v;
    v = $random(seed_var);
    return (v == 0) ? 32'h1 : v;                 // Zero seed would stall
  endfunction

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      {m_seed, m_state, m_run, m_good} <= '0;
      m_lane_q <= '0;
      m_word   <= '0;
    end
    else
    begin
      for (int q = 0; q < L; q++)
        m_lane_q[q] <= m_state[lane_sel[q]][7:0];  // Lane pick stage
      m_word <= build_word(m_lane_q, cfg);         // Mapping stage
      for (int i = 0; i < `BERT_GENS; i++)
      begin
        if (gen_ctrl[i].seed_ld)
          {m_seed[i], m_good[i]} <= {seed_data, seed_data != 0};
        if (gen_ctrl[i].restart)
          m_run[i] <= 1'b0;
        else if (gen_ctrl[i].start && m_good[i])
          m_run[i] <= 1'b1;
        if (gen_ctrl[i].seed_ld)
          m_state[i] <= seed_data;
        else if (gen_ctrl[i].restart)
          m_state[i] <= m_seed[i];
        else if (m_run[i])
          m_state[i] <= advance(m_state[i], gen_ctrl[i].ptrn_sel, steps_per_clock(cfg));
      end
    end
  end

  //------------------------------
  // Compare and drive tasks
  //------------------------------

  task automatic compare_word(input string name, input bert_pkg::bert_word_t got,
                              input bert_pkg::bert_word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_status(input string name, input logic [`BERT_GENS-1:0] got,
                                input logic [`BERT_GENS-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic compare_lanes(input string name, input bert_pkg::lane_bytes_t got,
                               input bert_pkg::lane_bytes_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Starts and ends on a falling edge
  task automatic pulse_ctrl(input logic [`BERT_GENS-1:0] mask, input int kind);
    for (int i = 0; i < `BERT_GENS; i++)
    begin
      if (mask[i] && kind == PULSE_START)
        gen_ctrl[i].start = 1'b1;
      else if (mask[i])
        gen_ctrl[i].restart = 1'b1;
    end
    @(negedge clk);
    for (int i = 0; i < `BERT_GENS; i++)
      {gen_ctrl[i].start, gen_ctrl[i].restart} = 2'b00;
  endtask

  task automatic load_seed(input int gen, input logic [31:0] value);
    seed_data = value;
    gen_ctrl[gen].seed_ld = 1'b1;
    @(negedge clk);
    gen_ctrl[gen].seed_ld = 1'b0;
  endtask

  task automatic check_cycles(input int n, input bit split);
    bert_pkg::bert_word_t lo;
    lo = '0;
    lo[2*L-1:0] = '1;                            // Gen1 region
    for (int k = 0; k < n; k++)
    begin
      @(negedge clk);
      if (k < 32)
        trace[k] = bert_data;
      if (split)
      begin
        compare_word("bert_data low", bert_data & lo, m_word & lo);
        compare_word("bert_data high", bert_data & ~lo, m_word & ~lo);
      end
      else
        compare_word("bert_data", bert_data, m_word);
    end
  endtask

  task automatic end_test(input string name, input int err_at_start);
    tests_run++;
    if (errors != err_at_start)
    begin
      tests_failed++;
      $display("Test %-12s FAILED with %0d errors", name, errors - err_at_start);
    end
    else
      $display("Test %-12s ok", name);
  endtask

  //------------------------------
  // Directed tests
  //------------------------------

  task automatic test_reset_state();
    int e0;
    e0 = errors;
    compare_word("bert_data", bert_data, '0);
    compare_status("seed_good", seed_good, '0);
    compare_status("gen_run", gen_run, '0);
    load_seed(0, 32'h0);
    pulse_ctrl('1, PULSE_START);                 // Must not run without a seed
    check_cycles(3, 1'b0);
    compare_status("gen_run", gen_run, '0);
    end_test("reset_state", e0);
  endtask

  task automatic test_pat32();
    int e0;
    e0 = errors;
    cfg.gen2_mode = 1'b1;
    cfg.sdr_mode  = 1'b0;
    cfg.fifo_mode = bert_pkg::FIFO_4X;           // Rotate 8 per clock
    lane_sel = bert_pkg::lane_sel_t'($random(seed_var));
    for (int i = 0; i < `BERT_GENS; i++)
    begin
      gen_ctrl[i].ptrn_sel = bert_pkg::PAT32;
      load_seed(i, random_seed());
    end
    pulse_ctrl('1, PULSE_START);
    compare_status("seed_good", seed_good, '1);
    compare_status("gen_run", gen_run, '1);
    check_cycles(20, 1'b0);
    end_test("pat32", e0);
  endtask

  task automatic test_prbs();
    int e0;
    e0 = errors;
    pulse_ctrl('1, PULSE_RESTART);
    for (int i = 0; i < `BERT_GENS; i++)
    begin
      gen_ctrl[i].ptrn_sel = bert_pkg::ptrn_sel_e'(i + 1);  // PRBS7 to PRBS31
      load_seed(i, random_seed());
    end
    pulse_ctrl('1, PULSE_START);
    for (int s = 1; s >= 0; s--)
      for (int f = 0; f < 4; f++)
      begin
        cfg.sdr_mode  = s[0];
        cfg.fifo_mode = bert_pkg::fifo_mode_e'(f);
        lane_sel = bert_pkg::lane_sel_t'($random(seed_var));
        check_cycles(14, 1'b0);
      end
    end_test("prbs", e0);
  endtask

  task automatic test_gen1();
    int e0;
    e0 = errors;
    for (int s = 0; s < 2; s++)
    begin
      cfg.gen2_mode = 1'b0;
      cfg.sdr_mode  = s[0];                      // DDR first then SDR
      cfg.fifo_mode = bert_pkg::FIFO_2X;
      pulse_ctrl('1, PULSE_RESTART);
      pulse_ctrl('1, PULSE_START);
      check_cycles(16, 1'b1);
    end
    end_test("gen1_map", e0);
  endtask

  task automatic test_restart();
    int e0;
    e0 = errors;
    cfg.gen2_mode = 1'b1;
    cfg.sdr_mode  = 1'b0;
    cfg.fifo_mode = bert_pkg::FIFO_1X;
    pulse_ctrl('1, PULSE_RESTART);
    for (int i = 0; i < `BERT_GENS; i++)
      load_seed(i, random_seed());
    check_cycles(2, 1'b0);                       // Seed settles in pipeline
    pulse_ctrl('1, PULSE_START);
    check_cycles(12, 1'b0);
    for (int k = 0; k < 12; k++)
      first_run[k] = trace[k];
    pulse_ctrl('1, PULSE_RESTART);               // Mid-run stop
    compare_status("gen_run", gen_run, '0);
    check_cycles(3, 1'b0);
    pulse_ctrl('1, PULSE_START);
    check_cycles(12, 1'b0);
    for (int k = 0; k < 12; k++)
      compare_word("replayed bert_data", trace[k], first_run[k]);
    end_test("restart", e0);
  endtask

  task automatic test_routing();
    int e0;
    logic [`BERT_GENS-1:0][31:0] seeds;
    bert_pkg::lane_bytes_t exp;
    e0 = errors;
    seeds = {32'hAAAA_AA96, 32'h5555_555A, 32'hF0F0_F0C3, 32'h0F0F_0F3C};
    pulse_ctrl('1, PULSE_RESTART);               // Generators hold still
    for (int i = 0; i < `BERT_GENS; i++)
      load_seed(i, seeds[i]);
    for (int r = 0; r < `BERT_GENS; r++)
    begin
      for (int q = 0; q < L; q++)
      begin
        lane_sel[q] = 2'((q + r) % `BERT_GENS);  // Rotate sources
        exp[q] = seeds[(q + r) % `BERT_GENS][7:0];
      end
      check_cycles(3, 1'b0);
      compare_lanes("recovered lane bytes", recover_lanes(bert_data), exp);
    end
    end_test("routing", e0);
  endtask

  //------------------------------
  // Clock, watchdog, main
  //------------------------------

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  initial
  begin
    #(WATCH_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("Test failures found");
    $finish;
  end

  initial
  begin
    seed_var = 93;
    {errors, checks, tests_run, tests_failed} = '0;
    rst_n = 1'b0;
    cfg = '0;
    gen_ctrl = '0;
    seed_data = '0;
    lane_sel = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset_state();
    test_pat32();
    test_prbs();
    test_gen1();
    test_restart();
    test_routing();
    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+hdl
hdl/bert_pkg.sv
hdl/bert_gen.sv
hdl/bert_lane_sel.sv
hdl/bert_bit_map.sv
hdl/bert_tx.sv
sim/bert_tx_checker.sv
sim/bert_tx_tb.sv
